/* source/icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

//////////////////////////////
// cache geometry
//////////////////////////////

// sets per way, and index width
`define ICACHE_SETS 32
`define ICACHE_SET_BITS 5

// stored tag is address bits 31 to 8
`define ICACHE_TAG_BITS 24

//////////////////////////////
// request queue
//////////////////////////////

`define ICACHE_QUEUE_LEN 6
`define ICACHE_PTR_BITS 3

// sequential blocks queued behind a fetch block
`define ICACHE_PREFETCH 2

`endif

/* source/icache_pkg.sv */
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_command_t;

  // address split into cached fields
  typedef struct packed {
    logic [63-3-`ICACHE_SET_BITS-`ICACHE_TAG_BITS:0] upper;
    logic [`ICACHE_TAG_BITS-1:0] tag;
    logic [`ICACHE_SET_BITS-1:0] set;
    logic [2:0] offset;
  } fetch_fields_t;

  typedef union packed {
    logic [63:0] word;
    fetch_fields_t fields;
  } fetch_addr_t;

  // one queued block, mem_tag stays 0 until memory accepts it
  typedef struct packed {
    logic [63:0] address;
    logic [3:0] mem_tag;
    logic valid;
  } mem_req_t;

  typedef struct packed {
    logic valid;
    logic [28:0] block;
    logic [63:0] data;
  } icache_fill_t;

  typedef struct packed {
    logic restart;
    logic [`ICACHE_PREFETCH-1:0] push;
    logic mark_sent;
    logic [3:0] sent_tag;
    logic retire_head;
    logic advance_wait;
  } queue_cmd_t;

endpackage

`default_nettype wire

/* source/icache_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_array
  import icache_pkg::*;
(
  input wire clock,
  input wire reset,
  input wire fetch_addr_t lookup_addr,
  input wire [63:0] head_addr,
  input wire icache_fill_t fill,
  output logic [63:0] lookup_data,
  output logic lookup_hit,
  output logic head_hit
);

  // lru holds the index of the older way
  logic [`ICACHE_SETS-1:0][1:0] valid;
  logic [`ICACHE_SETS-1:0] lru;
  logic [`ICACHE_TAG_BITS-1:0] tags [`ICACHE_SETS][2];
  logic [63:0] data [`ICACHE_SETS][2];

  fetch_addr_t head_view;
  fetch_addr_t fill_view;
  logic [1:0] lookup_ways;
  logic [1:0] head_ways;
  logic [1:0] fill_ways;
  logic lookup_bypass;
  logic head_bypass;
  logic fill_way;
  logic dup_tag;

  function automatic logic [1:0] match_ways(input logic [1:0] set_valid,
                                            input logic [`ICACHE_TAG_BITS-1:0] tag0,
                                            input logic [`ICACHE_TAG_BITS-1:0] tag1,
                                            input logic [`ICACHE_TAG_BITS-1:0] tag);
    logic [1:0] ways;
    ways[0] = set_valid[0] && (tag0 == tag);
    ways[1] = set_valid[1] && (tag1 == tag);
    return ways;
  endfunction

  assign head_view.word = head_addr;
  assign fill_view.word = {32'h0, fill.block, 3'h0};

  assign lookup_ways = match_ways(valid[lookup_addr.fields.set],
                                  tags[lookup_addr.fields.set][0],
                                  tags[lookup_addr.fields.set][1],
                                  lookup_addr.fields.tag);
  assign head_ways = match_ways(valid[head_view.fields.set],
                                tags[head_view.fields.set][0],
                                tags[head_view.fields.set][1],
                                head_view.fields.tag);
  assign fill_ways = match_ways(valid[fill_view.fields.set],
                                tags[fill_view.fields.set][0],
                                tags[fill_view.fields.set][1],
                                fill_view.fields.tag);

  // a block in the fill register counts as present
  assign lookup_bypass = fill.valid && (fill.block == lookup_addr.word[31:3]);
  assign head_bypass = fill.valid && (fill.block == head_view.word[31:3]);

  assign lookup_hit = (|lookup_ways) || lookup_bypass;
  assign lookup_data = lookup_bypass ? fill.data :
                       data[lookup_addr.fields.set][lookup_ways[1]];
  assign head_hit = (|head_ways) || head_bypass;

  // refresh a matching way, else first free way, else lru
  always_comb begin
    if (|fill_ways) begin
      fill_way = fill_ways[1];
    end else if (!valid[fill_view.fields.set][0]) begin
      fill_way = 1'b0;
    end else if (!valid[fill_view.fields.set][1]) begin
      fill_way = 1'b1;
    end else begin
      fill_way = lru[fill_view.fields.set];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
      lru <= '0;
    end else begin
      if (|lookup_ways) begin
        lru[lookup_addr.fields.set] <= ~lookup_ways[1];
      end
      if (fill.valid) begin
        valid[fill_view.fields.set][fill_way] <= 1'b1;
        lru[fill_view.fields.set] <= ~fill_way;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill.valid) begin
      tags[fill_view.fields.set][fill_way] <= fill_view.fields.tag;
      data[fill_view.fields.set][fill_way] <= fill.data;
    end
  end

  always_comb begin
    dup_tag = 1'b0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      if ((&valid[s]) && (tags[s][0] == tags[s][1])) begin
        dup_tag = 1'b1;
      end
    end
  end

  // repeated fills and prefetches of a cached block must not split it
  a_no_dup_tag: assert property (@(posedge clock) disable iff (reset) !dup_tag);

endmodule

`default_nettype wire

/* source/prefetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module prefetch_queue
  import icache_pkg::*;
(
  input wire clock,
  input wire reset,
  input wire fetch_addr_t fetch_addr,
  input wire queue_cmd_t cmd,
  output mem_req_t head,
  output mem_req_t send_entry,
  output mem_req_t wait_entry,
  output logic send_pending,
  output logic fetch_present,
  output logic [`ICACHE_PREFETCH-1:0] prefetch_present,
  output logic queue_full
);

  localparam logic [`ICACHE_PTR_BITS-1:0] QUEUE_END = `ICACHE_PTR_BITS'(`ICACHE_QUEUE_LEN);

  mem_req_t queue [`ICACHE_QUEUE_LEN];
  mem_req_t queue_next [`ICACHE_QUEUE_LEN];
  logic [`ICACHE_PTR_BITS-1:0] tail, tail_next;
  logic [`ICACHE_PTR_BITS-1:0] send_ptr, send_next;
  logic [`ICACHE_PTR_BITS-1:0] wait_ptr, wait_next;

  logic [63:0] fetch_block;
  logic [`ICACHE_PREFETCH-1:0][63:0] candidates;

  //////////////////////////////
  // associative lookup
  //////////////////////////////

  assign fetch_block = {fetch_addr.word[63:3], 3'h0};

  always_comb begin
    fetch_present = 1'b0;
    prefetch_present = '0;
    for (int i = 0; i < `ICACHE_PREFETCH; i++) begin
      candidates[i] = fetch_block + 64'((i + 1) * 8);
    end
    for (int j = 0; j < `ICACHE_QUEUE_LEN; j++) begin
      if (queue[j].valid && (queue[j].address == fetch_block)) begin
        fetch_present = 1'b1;
      end
      for (int i = 0; i < `ICACHE_PREFETCH; i++) begin
        if (queue[j].valid && (queue[j].address == candidates[i])) begin
          prefetch_present[i] = 1'b1;
        end
      end
    end
  end

  assign head = queue[0];
  assign send_entry = (send_ptr < QUEUE_END) ? queue[send_ptr] : '0;
  assign wait_entry = (wait_ptr < QUEUE_END) ? queue[wait_ptr] : '0;
  assign send_pending = (send_ptr < tail);
  assign queue_full = (tail == QUEUE_END);

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    queue_next = queue;
    tail_next = tail;
    send_next = send_ptr;
    wait_next = wait_ptr;

    if (cmd.advance_wait) begin
      wait_next = wait_next + 1'b1;
    end

    // retire shifts everything one slot toward the head
    if (cmd.retire_head) begin
      for (int j = 0; j < `ICACHE_QUEUE_LEN - 1; j++) begin
        queue_next[j] = queue[j + 1];
      end
      queue_next[`ICACHE_QUEUE_LEN - 1] = '0;
      tail_next = tail_next - 1'b1;
      if (send_next != '0) begin
        send_next = send_next - 1'b1;
      end
      if (wait_next != '0) begin
        wait_next = wait_next - 1'b1;
      end
    end

    if (cmd.mark_sent && (send_next < QUEUE_END)) begin
      queue_next[send_next].mem_tag = cmd.sent_tag;
      send_next = send_next + 1'b1;
    end

    if (cmd.restart) begin
      for (int j = 0; j < `ICACHE_QUEUE_LEN; j++) begin
        queue_next[j] = '0;
      end
      queue_next[0] = '{address: fetch_block, mem_tag: 4'h0, valid: 1'b1};
      tail_next = `ICACHE_PTR_BITS'(1);
      send_next = '0;
      wait_next = '0;
    end

    // pushes past the last slot are dropped
    for (int i = 0; i < `ICACHE_PREFETCH; i++) begin
      if (cmd.push[i] && (tail_next < QUEUE_END)) begin
        queue_next[tail_next] = '{address: candidates[i], mem_tag: 4'h0, valid: 1'b1};
        tail_next = tail_next + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int j = 0; j < `ICACHE_QUEUE_LEN; j++) begin
        queue[j] <= '0;
      end
      tail <= '0;
      send_ptr <= '0;
      wait_ptr <= '0;
    end else begin
      queue <= queue_next;
      tail <= tail_next;
      send_ptr <= send_next;
      wait_ptr <= wait_next;
    end
  end

  a_send_below_tail: assert property (@(posedge clock) disable iff (reset)
    send_ptr <= tail);
  a_wait_below_send: assert property (@(posedge clock) disable iff (reset)
    wait_ptr <= send_ptr);

endmodule

`default_nettype wire

/* source/icache_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_control
  import icache_pkg::*;
(
  input wire clock,
  input wire reset,
  input wire fetch_addr_t fetch_addr,
  input wire lookup_hit,
  input wire head_hit,
  input wire mem_req_t head,
  input wire mem_req_t send_entry,
  input wire mem_req_t wait_entry,
  input wire send_pending,
  input wire fetch_present,
  input wire [`ICACHE_PREFETCH-1:0] prefetch_present,
  input wire queue_full,
  input wire [3:0] mem2proc_response,
  input wire [63:0] mem2proc_data,
  input wire [3:0] mem2proc_tag,
  output queue_cmd_t cmd,
  output icache_fill_t fill,
  output bus_command_t proc2mem_command,
  output logic [63:0] proc2mem_addr
);

  logic [63:0] last_fetch;
  logic send_request;
  logic sending;
  logic changed_addr;
  logic accepted;
  logic rejected;
  logic restart;
  logic mem_done;
  logic fill_valid;
  logic [28:0] fill_block;
  logic [63:0] fill_data;

  // a registered send request can outlive the last pending entry
  assign sending = send_request && send_entry.valid;

  assign changed_addr = (fetch_addr.word != last_fetch);
  assign accepted = sending && (mem2proc_response != 4'h0);
  assign rejected = sending && (mem2proc_response == 4'h0);

  // a rejected load keeps the bus, so a new miss waits for it
  assign restart = !lookup_hit && !fetch_present && !rejected;

  assign mem_done = wait_entry.valid && (wait_entry.mem_tag != 4'h0) &&
                    (mem2proc_tag == wait_entry.mem_tag);

  //////////////////////////////
  // queue commands
  //////////////////////////////

  always_comb begin
    cmd = '0;
    cmd.restart = restart;
    for (int i = 0; i < `ICACHE_PREFETCH; i++) begin
      cmd.push[i] = restart || (changed_addr && !prefetch_present[i] && !queue_full);
    end
    cmd.mark_sent = accepted;
    cmd.sent_tag = mem2proc_response;
    // head on the bus stays until its load is taken
    cmd.retire_head = head_hit && head.valid && !(sending && (send_entry == head));
    cmd.advance_wait = mem_done;
  end

  //////////////////////////////
  // memory side
  //////////////////////////////

  assign proc2mem_command = sending ? BUS_LOAD : BUS_NONE;
  assign proc2mem_addr = sending ? send_entry.address : 64'h0;

  always_ff @(posedge clock) begin
    if (reset) begin
      last_fetch <= '1;
      send_request <= 1'b0;
      fill_valid <= 1'b0;
    end else begin
      last_fetch <= fetch_addr.word;
      send_request <= restart || (send_request ? rejected : send_pending);
      fill_valid <= mem_done;
    end
  end

  // fill takes the waiting entry's address, not the head's
  always_ff @(posedge clock) begin
    if (mem_done) begin
      fill_block <= wait_entry.address[31:3];
      fill_data <= mem2proc_data;
    end
  end

  assign fill = '{valid: fill_valid, block: fill_block, data: fill_data};

  a_hold_on_reject: assert property (@(posedge clock) disable iff (reset)
    (proc2mem_command == BUS_LOAD && mem2proc_response == 4'h0) |=>
      (proc2mem_command == BUS_LOAD && $stable(proc2mem_addr)));

endmodule

`default_nettype wire

/* source/icache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache
  import icache_pkg::*;
(
  input wire clock,
  input wire reset,
  input wire fetch_addr_t fetch_addr,
  input wire [3:0] mem2proc_response,
  input wire [63:0] mem2proc_data,
  input wire [3:0] mem2proc_tag,
  output logic [63:0] fetch_data,
  output logic fetch_valid,
  output bus_command_t proc2mem_command,
  output logic [63:0] proc2mem_addr
);

  queue_cmd_t cmd;
  icache_fill_t fill;
  mem_req_t head;
  mem_req_t send_entry;
  mem_req_t wait_entry;
  logic head_hit;
  logic send_pending;
  logic fetch_present;
  logic [`ICACHE_PREFETCH-1:0] prefetch_present;
  logic queue_full;

  icache_control i_control (
    .clock(clock),
    .reset(reset),
    .fetch_addr(fetch_addr),
    .lookup_hit(fetch_valid),
    .head_hit(head_hit),
    .head(head),
    .send_entry(send_entry),
    .wait_entry(wait_entry),
    .send_pending(send_pending),
    .fetch_present(fetch_present),
    .prefetch_present(prefetch_present),
    .queue_full(queue_full),
    .mem2proc_response(mem2proc_response),
    .mem2proc_data(mem2proc_data),
    .mem2proc_tag(mem2proc_tag),
    .cmd(cmd),
    .fill(fill),
    .proc2mem_command(proc2mem_command),
    .proc2mem_addr(proc2mem_addr)
  );

  // port 0 serves the fetch stage, port 1 the queue head
  icache_array i_array (
    .clock(clock),
    .reset(reset),
    .lookup_addr(fetch_addr),
    .head_addr(head.address),
    .fill(fill),
    .lookup_data(fetch_data),
    .lookup_hit(fetch_valid),
    .head_hit(head_hit)
  );

  prefetch_queue i_queue (
    .clock(clock),
    .reset(reset),
    .fetch_addr(fetch_addr),
    .cmd(cmd),
    .head(head),
    .send_entry(send_entry),
    .wait_entry(wait_entry),
    .send_pending(send_pending),
    .fetch_present(fetch_present),
    .prefetch_present(prefetch_present),
    .queue_full(queue_full)
  );

endmodule

`default_nettype wire

/* tests/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model
  import icache_pkg::*;
(
  input wire clock,
  input wire reset,
  input wire bus_command_t proc2mem_command,
  input wire [63:0] proc2mem_addr,
  output logic [3:0] mem2proc_response,
  output logic [63:0] mem2proc_data,
  output logic [3:0] mem2proc_tag
);

  localparam int LATENCY = 4;

  integer seed;
  logic reject;
  logic accepted;
  logic [3:0] next_tag;
  logic [3:0] pipe_tag [LATENCY];
  logic [63:0] pipe_addr [LATENCY];

  function automatic logic [63:0] block_data(input logic [63:0] addr);
    return {addr[31:0] ^ 32'hc0de_5a5a, addr[31:0]};
  endfunction

  initial begin
    seed = 32'h29fd;
  end

  // one draw per cycle, a quarter of the cycles refuse a load
  assign accepted = !reset && (proc2mem_command == BUS_LOAD) && !reject;
  assign mem2proc_response = accepted ? next_tag : 4'h0;

  always @(posedge clock) begin
    if (reset) begin
      reject <= 1'b0;
      next_tag <= 4'h1;
      for (int i = 0; i < LATENCY; i++) begin
        pipe_tag[i] <= 4'h0;
        pipe_addr[i] <= 64'h0;
      end
    end else begin
      reject <= (($random(seed) & 3) == 0);
      if (accepted) begin
        next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
      end
      pipe_tag[0] <= accepted ? next_tag : 4'h0;
      pipe_addr[0] <= proc2mem_addr;
      for (int i = 1; i < LATENCY; i++) begin
        pipe_tag[i] <= pipe_tag[i - 1];
        pipe_addr[i] <= pipe_addr[i - 1];
      end
    end
  end

  // in order, fixed delay, tag 0 means idle
  assign mem2proc_tag = reset ? 4'h0 : pipe_tag[LATENCY - 1];
  assign mem2proc_data = (mem2proc_tag != 4'h0) ? block_data(pipe_addr[LATENCY - 1]) : 64'h0;

endmodule

`default_nettype wire

/* tests/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb
  import icache_pkg::*;
();

  localparam int NUM_TESTS = 10;

  logic clock;
  logic reset;
  fetch_addr_t fetch_addr;
  logic [3:0] mem2proc_response;
  logic [63:0] mem2proc_data;
  logic [3:0] mem2proc_tag;
  logic [63:0] fetch_data;
  logic fetch_valid;
  bus_command_t proc2mem_command;
  logic [63:0] proc2mem_addr;

  // stimulus table, one row per test
  string test_name [NUM_TESTS];
  logic [63:0] test_addr [NUM_TESTS];
  int test_hold [NUM_TESTS];
  bit test_load [NUM_TESTS];
  int num_rows = 0;
  int total_hold = 0;
  bit table_ready = 1'b0;

  int errors = 0;
  int passed = 0;
  int failed = 0;
  int reject_count = 0;
  bit held_valid = 1'b0;
  logic [63:0] held_addr;

  icache i_icache (
    .clock(clock),
    .reset(reset),
    .fetch_addr(fetch_addr),
    .mem2proc_response(mem2proc_response),
    .mem2proc_data(mem2proc_data),
    .mem2proc_tag(mem2proc_tag),
    .fetch_data(fetch_data),
    .fetch_valid(fetch_valid),
    .proc2mem_command(proc2mem_command),
    .proc2mem_addr(proc2mem_addr)
  );

  mem_model i_memory (
    .clock(clock),
    .reset(reset),
    .proc2mem_command(proc2mem_command),
    .proc2mem_addr(proc2mem_addr),
    .mem2proc_response(mem2proc_response),
    .mem2proc_data(mem2proc_data),
    .mem2proc_tag(mem2proc_tag)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [63:0] block_data(input logic [63:0] addr);
    return {addr[31:0] ^ 32'hc0de_5a5a, addr[31:0]};
  endfunction

  task automatic add_test(input string name, input logic [63:0] addr, input int hold,
                          input bit load);
    test_name[num_rows] = name;
    test_addr[num_rows] = addr;
    test_hold[num_rows] = hold;
    test_load[num_rows] = load;
    total_hold = total_hold + hold;
    num_rows = num_rows + 1;
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
      errors = errors + 1;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
      passed = passed + 1;
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
      failed = failed + 1;
    end
  endtask

  // a refused load must come back unchanged next cycle
  task automatic watch_bus(input string name);
    if (held_valid) begin
      check_value(name, "proc2mem_command after reject", BUS_LOAD, proc2mem_command);
      check_value(name, "proc2mem_addr after reject", held_addr, proc2mem_addr);
    end
    held_valid = (proc2mem_command == BUS_LOAD) && (mem2proc_response == 4'h0);
    held_addr = proc2mem_addr;
    if (held_valid) begin
      reject_count = reject_count + 1;
    end
  endtask

  task automatic check_reset();
    int errors_before;
    errors_before = errors;
    for (int c = 0; c < 3; c++) begin
      @(posedge clock);
      if (c == 2) begin
        reset <= 1'b0;
      end
      @(negedge clock);
      check_value("reset", "proc2mem_command", BUS_NONE, proc2mem_command);
      check_value("reset", "fetch_valid", 64'h0, fetch_valid);
    end
    report_test("reset", errors_before);
  endtask

  task automatic run_test(input int idx);
    logic [63:0] block;
    logic [63:0] expected;
    int errors_before;
    bit seen_valid;
    bit seen_load;
    block = {test_addr[idx][63:3], 3'h0};
    expected = block_data(block);
    errors_before = errors;
    seen_valid = 1'b0;
    seen_load = 1'b0;
    @(posedge clock);
    fetch_addr.word <= test_addr[idx];
    for (int c = 0; c < test_hold[idx]; c++) begin
      @(negedge clock);
      watch_bus(test_name[idx]);
      if ((proc2mem_command == BUS_LOAD) && (proc2mem_addr == block)) begin
        seen_load = 1'b1;
      end
      if (fetch_valid && !seen_valid) begin
        seen_valid = 1'b1;
        check_value(test_name[idx], "fetch_data", expected, fetch_data);
      end
    end
    if (!seen_valid) begin
      $display("%s: fetch_valid never rose within %0d cycles", test_name[idx], test_hold[idx]);
      errors = errors + 1;
    end else begin
      check_value(test_name[idx], "fetch_valid at end", 64'h1, fetch_valid);
      check_value(test_name[idx], "fetch_data at end", expected, fetch_data);
    end
    if (seen_load != test_load[idx]) begin
      if (test_load[idx]) begin
        $display("%s: no load was issued for block %h", test_name[idx], block);
      end else begin
        $display("%s: a load was issued for cached block %h", test_name[idx], block);
      end
      errors = errors + 1;
    end
    report_test(test_name[idx], errors_before);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    reset = 1'b1;
    fetch_addr.word = 64'h0;
    // name, address, hold cycles, load expected
    add_test("cold_miss", 64'h1000, 40, 1'b1);
    add_test("prefetch_next", 64'h1008, 20, 1'b0);
    add_test("prefetch_second", 64'h1010, 20, 1'b0);
    add_test("hit_again", 64'h1000, 12, 1'b0);
    add_test("hit_offset", 64'h1004, 12, 1'b0);
    // set 8, three tags
    add_test("repl_a", 64'h2040, 40, 1'b1);
    add_test("repl_b", 64'h2140, 40, 1'b1);
    add_test("repl_c", 64'h2240, 40, 1'b1);
    add_test("repl_a_again", 64'h2040, 40, 1'b1);
    add_test("repl_c_hit", 64'h2244, 12, 1'b0);
    table_ready = 1'b1;

    check_reset();
    for (int i = 0; i < num_rows; i++) begin
      run_test(i);
    end
    if (reject_count == 0) begin
      $display("memory never rejected a load during the run");
      errors = errors + 1;
    end

    $display("summary: %0d tests, %0d ok, %0d failed, %0d errors, %0d rejected loads",
             num_rows + 1, passed, failed, errors, reject_count);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog, all holds plus a margin
  initial begin
    wait (table_ready);
    #((total_hold + 50) * 4);
    $display("watchdog expired after %0d cycles, tests did not finish", total_hold + 50);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/icache_pkg.sv
source/icache_array.sv
source/prefetch_queue.sv
source/icache_control.sv
source/icache.sv
tests/mem_model.sv
tests/icache_tb.sv
